//--- common/pkg_blas.sv
/*
 * Shared types of the matrix-vector engine
 * Word, address, unit and issue widths, opcode and command enums,
 * host, chain, memory and issue structs
 */

package pkg_blas;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////
	typedef logic [31:0]	data_t;
	typedef logic [5:0]		addr_t;
	typedef logic [2:0]		unit_id_t;
	typedef logic [7:0]		unit_mask_t;
	typedef logic [3:0]		issue_no_t;

	localparam int DMEM_WORDS = 2 ** $bits(addr_t);

	////////////////////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////////////////////
	typedef enum logic [1:0] {
		OP_ADD,
		OP_SUB,
		OP_MUL,			// Low half of the product
		OP_CPY			// dst gets operand a
	} op_t;

	typedef enum logic [1:0] {
		CMD_NOP,
		CMD_STORE,
		CMD_LOAD,
		CMD_EXEC
	} cmd_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_DRAIN,
		ST_EXEC
	} ctrl_state_t;

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		op_t		op;
		addr_t		dst;
		addr_t		src_a;
		addr_t		src_b;
	} instr_t;

	typedef struct packed {
		cmd_t		cmd;
		unit_id_t	unit;
		addr_t		addr;
		data_t		data;
		instr_t		instr;
		unit_mask_t	mask;
	} host_if_t;

	typedef struct packed {
		logic		valid;
		data_t		data;
	} host_ret_t;

	// Forward chain packet
	typedef struct packed {
		logic		valid;
		logic		is_load;
		unit_id_t	unit;
		addr_t		addr;
		data_t		data;
	} route_t;

	typedef struct packed {
		logic		valid;
		data_t		data;
	} ret_t;

	typedef struct packed {
		logic		en;
		logic		we;
		addr_t		addr;
		data_t		data;
	} mem_req_t;

	typedef struct packed {
		logic		start;
		issue_no_t	no;
		instr_t		instr;
		unit_mask_t	mask;
	} issue_t;

	typedef struct packed {
		ctrl_state_t	state;
		issue_no_t		last_commit;
	} stat_t;

endpackage

//--- source/router.sv
/*
 * Chain router stage
 * Local delivery or forwarding of packets, merge of load returns
 */

module router
	import pkg_blas::*;
#(
	parameter int UNIT_ID = 0
)(
	input	logic		clock,
	input	logic		rst_n,
	input	route_t		fwd_in,
	output	route_t		fwd_out,
	input	ret_t		ret_in,
	output	ret_t		ret_out,
	output	mem_req_t	mem_req,
	input	data_t		mem_rdata
);

	logic	local_hit;
	logic	rd_pend;	// Read data arrives this cycle

	assign local_hit = fwd_in.valid && (fwd_in.unit == unit_id_t'(UNIT_ID));

	assign mem_req.en	= local_hit;
	assign mem_req.we	= !fwd_in.is_load;
	assign mem_req.addr	= fwd_in.addr;
	assign mem_req.data	= fwd_in.data;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			fwd_out.valid	<= 1'b0;
			rd_pend			<= 1'b0;
			ret_out.valid	<= 1'b0;
		end else begin
			fwd_out.valid	<= fwd_in.valid && !local_hit;
			rd_pend			<= local_hit && fwd_in.is_load;
			ret_out.valid	<= rd_pend || ret_in.valid;
		end
	end

	always_ff @(posedge clock) begin
		fwd_out.is_load	<= fwd_in.is_load;
		fwd_out.unit	<= fwd_in.unit;
		fwd_out.addr	<= fwd_in.addr;
		fwd_out.data	<= fwd_in.data;
		ret_out.data	<= rd_pend ? mem_rdata : ret_in.data;	// Only one load in flight
	end

endmodule

//--- tpu/dmem.sv
/*
 * Local data memory of a unit
 * Route port and unit port, registered read on both
 */

module dmem
	import pkg_blas::*;
(
	input	logic		clock,
	input	mem_req_t	rt_req,
	output	data_t		rt_rdata,
	input	mem_req_t	pu_req,
	output	data_t		pu_rdata
);

	data_t	mem [0:DMEM_WORDS-1];

	// The drain keeps the two ports from writing together
	always_ff @(posedge clock) begin
		if (rt_req.en && rt_req.we) begin
			mem[rt_req.addr] <= rt_req.data;
		end
		if (pu_req.en && pu_req.we) begin
			mem[pu_req.addr] <= pu_req.data;
		end
	end

	always_ff @(posedge clock) begin
		if (rt_req.en) begin
			rt_rdata <= mem[rt_req.addr];
		end
	end

	always_ff @(posedge clock) begin
		if (pu_req.en) begin
			pu_rdata <= mem[pu_req.addr];	// Old word on a write
		end
	end

endmodule

//--- tpu/tpu.sv
/*
 * Processing unit
 * Operand fetch, ALU and write back for one broadcast instruction
 */

module tpu
	import pkg_blas::*;
#(
	parameter int UNIT_ID = 0
)(
	input	logic		clock,
	input	logic		rst_n,
	input	issue_t		issue,
	output	mem_req_t	mem_req,
	input	data_t		mem_rdata,
	output	logic		term
);

	typedef enum logic [1:0] {
		PU_IDLE,
		PU_RD_B,
		PU_WR
	} pu_state_t;

	pu_state_t	state;
	instr_t		instr;
	data_t		opa;
	data_t		result;
	logic		go;

	assign go = issue.start && issue.mask[UNIT_ID];

	// Operand b comes straight from the memory port
	always_comb begin
		case (instr.op)
			OP_ADD:		result = opa + mem_rdata;
			OP_SUB:		result = opa - mem_rdata;
			OP_MUL:		result = opa * mem_rdata;
			default:	result = opa;
		endcase
	end

	always_comb begin
		mem_req.en		= 1'b0;
		mem_req.we		= 1'b0;
		mem_req.addr	= issue.instr.src_a;	// First read straight off the broadcast
		mem_req.data	= result;
		case (state)
			PU_IDLE: mem_req.en = go;
			PU_RD_B: begin
				mem_req.en		= 1'b1;
				mem_req.addr	= instr.src_b;
			end
			PU_WR: begin
				mem_req.en		= 1'b1;
				mem_req.we		= 1'b1;
				mem_req.addr	= instr.dst;
			end
			default: mem_req.en = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state	<= PU_IDLE;
			term	<= 1'b0;
		end else begin
			term <= (state == PU_WR);	// Pulses with the write
			case (state)
				PU_IDLE: begin
					if (go) begin
						state <= PU_RD_B;
					end
				end
				PU_RD_B:	state <= PU_WR;
				default:	state <= PU_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == PU_IDLE && go) begin
			instr <= issue.instr;
		end
		if (state == PU_RD_B) begin
			opa <= mem_rdata;
		end
	end

endmodule

//--- source/issue_ctrl.sv
/*
 * Host command controller
 * Store and load packets into the chain, load return to the host,
 * drain timer ahead of each execute, issue numbering and commit status
 */

module issue_ctrl
	import pkg_blas::*;
#(
	parameter int NUM_UNITS = 4
)(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		req,
	input	host_if_t	host_in,
	output	route_t		route_out,
	input	ret_t		route_ret,
	output	host_ret_t	host_out,
	output	issue_t		issue,
	input	logic		commit,
	input	issue_no_t	commit_no,
	output	logic		busy,
	output	stat_t		status
);

	localparam logic [3:0] DRAIN_INIT = 4'(NUM_UNITS + 1);	// NUM_UNITS+2 drain cycles

	ctrl_state_t	state;
	logic [3:0]		drain_cnt;
	issue_no_t		last_commit;

	logic			cmd_req;
	logic			is_route;
	logic			drain_done;
	logic			ld_done;

	assign cmd_req		= req && (state == ST_IDLE);
	assign is_route		= cmd_req && (host_in.cmd == CMD_STORE || host_in.cmd == CMD_LOAD);
	assign drain_done	= (state == ST_DRAIN) && (drain_cnt == '0);
	assign ld_done		= (state == ST_LOAD) && route_ret.valid;

	////////////////////////////////////////////////////////////////////////////
	// Command FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state		<= ST_IDLE;
			drain_cnt	<= '0;
			last_commit	<= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (cmd_req && host_in.cmd == CMD_LOAD) begin
						state <= ST_LOAD;
					end else if (cmd_req && host_in.cmd == CMD_EXEC) begin
						state		<= ST_DRAIN;
						drain_cnt	<= DRAIN_INIT;
					end
				end
				ST_LOAD: begin
					if (route_ret.valid) begin
						state <= ST_IDLE;
					end
				end
				ST_DRAIN: begin
					if (drain_cnt == '0) begin
						state <= ST_EXEC;
					end else begin
						drain_cnt <= drain_cnt - 4'd1;
					end
				end
				ST_EXEC: begin
					if (commit) begin
						state		<= ST_IDLE;
						last_commit	<= commit_no;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// One chain packet per store or load
	always_ff @(posedge clock) begin
		route_out.is_load	<= (host_in.cmd == CMD_LOAD);
		route_out.unit		<= host_in.unit;
		route_out.addr		<= host_in.addr;
		route_out.data		<= host_in.data;
		if (!rst_n) begin
			route_out.valid <= 1'b0;
		end else begin
			route_out.valid <= is_route;
		end
	end

	always_ff @(posedge clock) begin
		if (ld_done) begin
			host_out.data <= route_ret.data;
		end
		if (!rst_n) begin
			host_out.valid <= 1'b0;
		end else begin
			host_out.valid <= ld_done;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Execute broadcast
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (cmd_req && host_in.cmd == CMD_EXEC) begin
			issue.instr	<= host_in.instr;
			issue.mask	<= host_in.mask;
		end
		if (!rst_n) begin
			issue.start	<= 1'b0;
			issue.no	<= '0;
		end else begin
			issue.start	<= drain_done;
			if (drain_done) begin
				issue.no <= issue.no + issue_no_t'(1);	// First execute is 1
			end
		end
	end

	assign busy					= (state != ST_IDLE);
	assign status.state			= state;
	assign status.last_commit	= last_commit;

endmodule

//--- source/commit_agg.sv
/*
 * Commit aggregator
 * Counts unit terminations against the enabled units of an execute
 */

module commit_agg
	import pkg_blas::*;
#(
	parameter int NUM_UNITS = 4
)(
	input	logic					clock,
	input	logic					rst_n,
	input	issue_t					issue,
	input	logic [NUM_UNITS-1:0]	term,
	output	logic					commit,
	output	issue_no_t				commit_no
);

	localparam unit_mask_t UNIT_EXIST = unit_mask_t'((1 << NUM_UNITS) - 1);

	logic		active;
	logic [3:0]	expect_cnt;
	logic [3:0]	term_cnt;
	logic [3:0]	n_en;

	function automatic logic [3:0] popcnt(input unit_mask_t v);
		logic [3:0] n;
		n = '0;
		for (int i = 0; i < $bits(unit_mask_t); i++) begin
			n = n + 4'(v[i]);
		end
		return n;
	endfunction

	// Mask bits beyond the last unit are ignored
	assign n_en = popcnt(issue.mask & UNIT_EXIST);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			active		<= 1'b0;
			commit		<= 1'b0;
			expect_cnt	<= '0;
			term_cnt	<= '0;
		end else if (issue.start) begin
			active		<= (n_en != '0);
			commit		<= (n_en == '0);	// Empty mask commits at once
			expect_cnt	<= n_en;
			term_cnt	<= '0;
		end else if (active && term_cnt == expect_cnt) begin
			active		<= 1'b0;
			commit		<= 1'b1;
		end else begin
			commit		<= 1'b0;
			term_cnt	<= term_cnt + popcnt(unit_mask_t'(term));
		end
	end

	always_ff @(posedge clock) begin
		if (issue.start) begin
			commit_no <= issue.no;
		end
	end

endmodule

//--- source/blas_engine.sv
/*
 * Engine top level
 * Controller, commit aggregator and one router, unit and memory per column
 */

module blas_engine
	import pkg_blas::*;
#(
	parameter int NUM_UNITS = 4
)(
	input	logic		clock,
	input	logic		rst_n,
	input	logic		req,
	input	host_if_t	host_in,
	output	host_ret_t	host_out,
	output	stat_t		status,
	output	logic		busy
);

	issue_t					issue;
	logic					commit;
	issue_no_t				commit_no;
	logic [NUM_UNITS-1:0]	term;

	route_t		fwd			[NUM_UNITS-1:0];
	ret_t		ret			[NUM_UNITS:0];
	mem_req_t	rt_req		[NUM_UNITS-1:0];
	data_t		rt_rdata	[NUM_UNITS-1:0];
	mem_req_t	pu_req		[NUM_UNITS-1:0];
	data_t		pu_rdata	[NUM_UNITS-1:0];

	assign ret[NUM_UNITS] = '0;	// Nothing returns from past the last unit

	issue_ctrl #(.NUM_UNITS(NUM_UNITS)) issue_ctrl (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.req(		req			),
		.host_in(	host_in		),
		.route_out(	fwd[0]		),
		.route_ret(	ret[0]		),
		.host_out(	host_out	),
		.issue(		issue		),
		.commit(	commit		),
		.commit_no(	commit_no	),
		.busy(		busy		),
		.status(	status		)
	);

	commit_agg #(.NUM_UNITS(NUM_UNITS)) commit_agg (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.issue(		issue		),
		.term(		term		),
		.commit(	commit		),
		.commit_no(	commit_no	)
	);

	////////////////////////////////////////////////////////////////////////////
	// Unit columns
	////////////////////////////////////////////////////////////////////////////
	for (genvar k = 0; k < NUM_UNITS; k++) begin : g_unit
		if (k < NUM_UNITS - 1) begin : g_mid
			router #(.UNIT_ID(k)) router (
				.clock(		clock		),
				.rst_n(		rst_n		),
				.fwd_in(	fwd[k]		),
				.fwd_out(	fwd[k+1]	),
				.ret_in(	ret[k+1]	),
				.ret_out(	ret[k]		),
				.mem_req(	rt_req[k]	),
				.mem_rdata(	rt_rdata[k]	)
			);
		end else begin : g_last
			router #(.UNIT_ID(k)) router (
				.clock(		clock		),
				.rst_n(		rst_n		),
				.fwd_in(	fwd[k]		),
				.fwd_out(				),
				.ret_in(	ret[k+1]	),
				.ret_out(	ret[k]		),
				.mem_req(	rt_req[k]	),
				.mem_rdata(	rt_rdata[k]	)
			);
		end

		tpu #(.UNIT_ID(k)) tpu (
			.clock(		clock		),
			.rst_n(		rst_n		),
			.issue(		issue		),
			.mem_req(	pu_req[k]	),
			.mem_rdata(	pu_rdata[k]	),
			.term(		term[k]		)
		);

		dmem dmem (
			.clock(		clock		),
			.rt_req(	rt_req[k]	),
			.rt_rdata(	rt_rdata[k]	),
			.pu_req(	pu_req[k]	),
			.pu_rdata(	pu_rdata[k]	)
		);
	end

endmodule

//--- tests/tb_blas_engine.sv
/*
 * Testbench for the matrix-vector engine
 * LFSR stimulus, memory model of every unit, compare tasks and error counts
 */

module tb_blas_engine
	import pkg_blas::*;
();

	localparam int NUM_UNITS = 4;
	localparam int WAIT_LIMIT = 100;	// Cycles

	logic		clock;
	logic		rst_n;
	logic		req;
	host_if_t	host_in;
	host_ret_t	host_out;
	stat_t		status;
	logic		busy;

	data_t		model [NUM_UNITS][DMEM_WORDS];
	issue_no_t	issue_cnt;
	logic [15:0]	lfsr;
	int			checks;
	int			errors;
	int			timeouts;

	blas_engine #(.NUM_UNITS(NUM_UNITS)) UUT (
		.clock(		clock		),
		.rst_n(		rst_n		),
		.req(		req			),
		.host_in(	host_in		),
		.host_out(	host_out	),
		.status(	status		),
		.busy(		busy		)
	);

	always #2 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and model helpers
	////////////////////////////////////////////////////////////////////////////
	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic data_t apply_op(input op_t op, input data_t a, input data_t b);
		case (op)
			OP_ADD:		return a + b;
			OP_SUB:		return a - b;
			OP_MUL:		return a * b;	// Low word only
			default:	return a;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////
	task automatic check_data(input string name, input data_t got, input data_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_issue(input string name, input issue_no_t got, input issue_no_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_status(input string name, input stat_t got, input stat_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Host commands
	////////////////////////////////////////////////////////////////////////////
	// Called a short delay after an edge and returns likewise after the next one
	task automatic send_cmd(input cmd_t cmd, input int unit, input addr_t addr,
			input data_t data, input instr_t instr, input unit_mask_t mask);
		req				= 1'b1;
		host_in.cmd		= cmd;
		host_in.unit	= unit_id_t'(unit);
		host_in.addr	= addr;
		host_in.data	= data;
		host_in.instr	= instr;
		host_in.mask	= mask;
		@(posedge clock);
		#1;
		req		= 1'b0;
		host_in	= '0;
	endtask

	task automatic store_word(input int unit, input addr_t addr, input data_t data);
		send_cmd(CMD_STORE, unit, addr, data, '0, '0);
		model[unit][addr] = data;
		check_flag("busy", busy, 1'b0);
	endtask

	task automatic load_word(input int unit, input addr_t addr);
		int		cycles;
		stat_t	exp;
		send_cmd(CMD_LOAD, unit, addr, '0, '0, '0);
		exp.state		= ST_LOAD;
		exp.last_commit	= issue_cnt;
		cycles = 0;
		// Held busy in ST_LOAD until the data returns
		while (!host_out.valid && cycles < WAIT_LIMIT) begin
			check_flag("busy", busy, 1'b1);
			check_status("status", status, exp);
			@(posedge clock);
			#1;
			cycles++;
		end
		if (!host_out.valid) begin
			timeouts++;
			$display("Timeout waiting for load data from unit %0d address %0d", unit, addr);
		end else begin
			check_data($sformatf("host_out.data (unit %0d, addr 0x%h)", unit, addr),
				host_out.data, model[unit][addr]);
			check_flag("busy", busy, 1'b0);
			@(posedge clock);
			#1;
			check_flag("host_out.valid", host_out.valid, 1'b0);	// Single pulse
		end
	endtask

	task automatic run_exec(input instr_t instr, input unit_mask_t mask);
		data_t	a;
		data_t	b;
		stat_t	exp;
		int		cycles;
		// Both operands are read before dst is written
		for (int u = 0; u < NUM_UNITS; u++) begin
			if (mask[u]) begin
				a = model[u][instr.src_a];
				b = model[u][instr.src_b];
				model[u][instr.dst] = apply_op(instr.op, a, b);
			end
		end
		exp.last_commit = issue_cnt;
		issue_cnt = issue_cnt + issue_no_t'(1);
		send_cmd(CMD_EXEC, 0, '0, '0, instr, mask);
		check_flag("busy", busy, 1'b1);
		cycles = 0;
		while (busy && cycles < WAIT_LIMIT) begin
			if (cycles < NUM_UNITS + 2) begin
				exp.state = ST_DRAIN;	// Chain empties ahead of the broadcast
			end else begin
				exp.state = ST_EXEC;
			end
			check_status("status", status, exp);
			@(posedge clock);
			#1;
			cycles++;
		end
		if (busy) begin
			timeouts++;
			$display("Timeout waiting for execute %0d to commit", issue_cnt);
		end else begin
			exp.state		= ST_IDLE;
			exp.last_commit	= issue_cnt;
			check_issue("status.last_commit", status.last_commit, issue_cnt);
			check_status("status", status, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////
	initial begin
		instr_t		instr;
		unit_mask_t	mask;
		stat_t		exp;
		clock		= 1'b0;
		rst_n		= 1'b0;
		req			= 1'b0;
		host_in		= '0;
		lfsr		= 16'd78;
		issue_cnt	= '0;
		checks		= 0;
		errors		= 0;
		timeouts	= 0;
		repeat (2) @(posedge clock);
		#1;
		rst_n = 1'b1;

		exp.state		= ST_IDLE;
		exp.last_commit	= '0;
		check_flag("busy", busy, 1'b0);
		check_flag("host_out.valid", host_out.valid, 1'b0);
		check_status("status", status, exp);

		// Fill every unit, one store per cycle
		for (int u = 0; u < NUM_UNITS; u++) begin
			for (int a = 0; a < DMEM_WORDS; a++) begin
				store_word(u, addr_t'(a), rand_bits(32));
			end
		end

		repeat (24) begin
			load_word(int'(rand_bits(3)) % NUM_UNITS, addr_t'(rand_bits(6)));
		end

		repeat (20) begin
			instr.op	= op_t'(rand_bits(2));
			instr.dst	= addr_t'(rand_bits(6));
			instr.src_a	= addr_t'(rand_bits(6));
			instr.src_b	= addr_t'(rand_bits(6));
			mask		= unit_mask_t'(rand_bits(8));
			run_exec(instr, mask);
			for (int u = 0; u < NUM_UNITS; u++) begin
				load_word(u, instr.dst);
			end
		end

		// Empty mask commits and leaves memory alone
		instr.op	= OP_CPY;
		instr.dst	= addr_t'(rand_bits(6));
		instr.src_a	= addr_t'(rand_bits(6));
		instr.src_b	= addr_t'(rand_bits(6));
		run_exec(instr, '0);
		for (int u = 0; u < NUM_UNITS; u++) begin
			load_word(u, instr.dst);
		end

		// Stores still in the chain ahead of a load to the farthest unit
		repeat (4) begin
			store_word(NUM_UNITS - 1, 6'h15, rand_bits(32));
		end
		load_word(NUM_UNITS - 1, 6'h15);
		store_word(0, 6'h15, rand_bits(32));
		store_word(NUM_UNITS - 1, 6'h15, rand_bits(32));
		load_word(NUM_UNITS - 1, 6'h15);

		$display("Checks run %0d, value errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- files.f
common/pkg_blas.sv
source/router.sv
tpu/dmem.sv
tpu/tpu.sv
source/issue_ctrl.sv
source/commit_agg.sv
source/blas_engine.sv
tests/tb_blas_engine.sv

//--- Makefile
# Verilator flow for the matrix-vector engine

TB  = tb_blas_engine
RTL = blas_engine

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module $(RTL)

sim:
	verilator --binary -j 0 -f files.f --top-module $(TB)
	./obj_dir/V$(TB) | tee sim.log
	@if grep -q "All checks passed" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
